//--- sys_defs.svh
`ifndef SYS_DEFS_SVH
`define SYS_DEFS_SVH

// Audio sample width
`define SAMPLE_W 16

// Host data word width
`define HOST_W 16

// Attenuation field, mute bit on top of a 4-bit shift
`define ATT_W 5

// Main-board LED panel
`define LED_W 8

// Host command codes
`define CMD_LED 8'h25
`define CMD_VOL 8'h26

`endif

//--- host_pkg.sv
`include "sys_defs.svh"

package host_pkg;

	// One word from the host
	typedef logic [`HOST_W-1:0] host_word_t;

	// Host command port levels
	typedef struct packed {
		logic       sel;
		logic       hclk;
		host_word_t din;
	} host_bus_t;

	// LED panel pattern
	typedef logic [`LED_W-1:0] led_t;

	// Receiver FSM
	typedef enum logic {
		IDLE_CMD,
		TAKE_DATA
	} rx_state_t;

endpackage

//--- audio_pkg.sv
`include "sys_defs.svh"

package audio_pkg;

	typedef logic signed [`SAMPLE_W-1:0] sample_t;

	// One guard bit for sums of two samples
	typedef logic signed [`SAMPLE_W:0] wide_t;

	// Top bit mutes, low bits are the shift count
	typedef logic [`ATT_W-1:0] att_t;

	// Crossfeed mode, 0 is none and 3 is the strongest
	typedef logic [1:0] mix_t;

	typedef struct packed {
		mix_t mix;
		logic is_signed;
	} audio_ctl_t;

	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

	typedef struct packed {
		wide_t left;
		wide_t right;
	} stereo_wide_t;

endpackage

//--- host_cmd_rx.sv
`timescale 1ns/1ps

`include "sys_defs.svh"

module host_cmd_rx
	import host_pkg::*;
	import audio_pkg::*;
(
	input  logic      clk,
	input  logic      resetd,

	input  host_bus_t i_host,
	input  led_t      i_led_status,

	output logic      o_host_ack,
	output att_t      o_att,
	output led_t      o_led
);

logic       hclk_d;
logic       strobe;
rx_state_t  state;
logic [7:0] cmd;
led_t       led_mask;
led_t       led_state;

/////////////  Host strobe  //////////////

// New word when the host clock has just gone high
assign strobe = i_host.hclk & ~hclk_d;

// Ack trails hclk by two cycles
always_ff @(posedge clk) begin
	if (resetd) begin
		hclk_d     <= 1'b0;
		o_host_ack <= 1'b0;
	end else begin
		hclk_d     <= i_host.hclk;
		o_host_ack <= hclk_d;
	end
end

//////////  Command sequencing  //////////

always_ff @(posedge clk) begin
	if (resetd) begin
		state     <= IDLE_CMD;
		cmd       <= '0;
		o_att     <= '0;
		led_mask  <= '0;
		led_state <= '0;
	end else if (!i_host.sel) begin
		// Deselect drops any pending command
		state <= IDLE_CMD;
	end else if (strobe) begin
		case (state)
			IDLE_CMD: begin
				cmd   <= i_host.din[7:0];
				state <= TAKE_DATA;
			end
			TAKE_DATA: begin
				// Every further word is data for the held command
				case (cmd)
					`CMD_LED: begin
						led_mask  <= i_host.din[`HOST_W-1 -: `LED_W];
						led_state <= i_host.din[`LED_W-1:0];
					end
					`CMD_VOL: o_att <= i_host.din[`ATT_W-1:0];
					default: ;
				endcase
			end
			default: state <= IDLE_CMD;
		endcase
	end
end

// Override bits take the host state, the rest show the core
assign o_led = (led_mask & led_state) | (~led_mask & i_led_status);

/////////////  Assertions  ///////////////

ap_ack_delay: assert property (
	@(posedge clk) disable iff (resetd)
	!$past(resetd, 1) && !$past(resetd, 2) |-> o_host_ack == $past(i_host.hclk, 2)
) else $error("host ack is not hclk delayed by two cycles");

ap_sel_idle: assert property (
	@(posedge clk) disable iff (resetd)
	$past(!i_host.sel) |-> state == IDLE_CMD
) else $error("receiver left idle while select was low");

endmodule

//--- audio_mix_channel.sv
`timescale 1ns/1ps

`include "sys_defs.svh"

module audio_mix_channel
	import audio_pkg::*;
(
	input  logic       clk,
	input  logic       resetd,

	input  sample_t    i_core,
	input  sample_t    i_linux,
	input  audio_ctl_t i_ctl,
	input  sample_t    i_pre_other,

	output sample_t    o_pre,
	output wide_t      o_mixed
);

sample_t tap1;
sample_t tap2;
sample_t tap3;
sample_t core_held;
wide_t   core_wide;
wide_t   sum;
wide_t   linux_wide;
wide_t   other_wide;
wide_t   mix_next;

assign linux_wide = {i_linux[`SAMPLE_W-1], i_linux};
assign other_wide = {i_pre_other[`SAMPLE_W-1], i_pre_other};

////////////  Glitch filter  /////////////

// Held value moves only once three taps agree
always_ff @(posedge clk) begin
	if (resetd) begin
		tap1      <= '0;
		tap2      <= '0;
		tap3      <= '0;
		core_held <= '0;
	end else begin
		tap1 <= i_core;
		tap2 <= tap1;
		tap3 <= tap2;
		if (tap1 == tap2 && tap2 == tap3)
			core_held <= tap3;
	end
end

/////////////  Sum and mix  //////////////

always_ff @(posedge clk) begin
	if (resetd) begin
		core_wide <= '0;
		sum       <= '0;
		o_pre     <= '0;
		o_mixed   <= '0;
	end else begin
		// Unsigned input is halved to fit the positive range
		if (i_ctl.is_signed)
			core_wide <= {core_held[`SAMPLE_W-1], core_held};
		else
			core_wide <= {2'b00, core_held[`SAMPLE_W-1:1]};
		sum     <= core_wide + linux_wide;
		o_pre   <= sum[`SAMPLE_W:1];
		o_mixed <= mix_next;
	end
end

// Crossfeed of the opposite channel
always_comb begin
	case (i_ctl.mix)
		2'd0: mix_next = sum;
		2'd1: mix_next = sum - (sum >>> 3) + (other_wide >>> 2);
		2'd2: mix_next = sum - (sum >>> 2) + (other_wide >>> 1);
		default: mix_next = (sum >>> 1) + other_wide;
	endcase
end

endmodule

//--- audio_out_stage.sv
`timescale 1ns/1ps

`include "sys_defs.svh"

module audio_out_stage
	import audio_pkg::*;
(
	input  logic         clk,
	input  logic         resetd,

	input  stereo_wide_t i_mixed,
	input  att_t         i_att,

	output stereo_t      o_audio
);

stereo_wide_t shifted;

// Mute or arithmetic shift down
function automatic wide_t attenuate(input wide_t v, input att_t att);
	if (att[`ATT_W-1])
		return '0;
	return v >>> att[`ATT_W-2:0];
endfunction

// Saturate to the sample range
function automatic sample_t clamp(input wide_t v);
	if (v[`SAMPLE_W] != v[`SAMPLE_W-1])
		return {v[`SAMPLE_W], {(`SAMPLE_W-1){~v[`SAMPLE_W]}}};
	return v[`SAMPLE_W-1:0];
endfunction

always_ff @(posedge clk) begin
	if (resetd) begin
		shifted <= '0;
		o_audio <= '0;
	end else begin
		shifted.left  <= attenuate(i_mixed.left, i_att);
		shifted.right <= attenuate(i_mixed.right, i_att);
		o_audio.left  <= clamp(shifted.left);
		o_audio.right <= clamp(shifted.right);
	end
end

// Mute must reach both outputs through both registers
ap_mute_zero: assert property (
	@(posedge clk) disable iff (resetd)
	i_att[`ATT_W-1] ##1 i_att[`ATT_W-1] |=> o_audio == '0
) else $error("audio output not silent after mute");

endmodule

//--- hps_audio_core.sv
`timescale 1ns/1ps

module hps_audio_core
	import host_pkg::*;
	import audio_pkg::*;
(
	input  logic       clk,
	input  logic       resetd,

	input  host_bus_t  i_host,
	input  stereo_t    i_core_audio,
	input  stereo_t    i_linux_audio,
	input  audio_ctl_t i_audio_ctl,
	input  led_t       i_led_status,

	output logic       o_host_ack,
	output stereo_t    o_audio,
	output led_t       o_led
);

att_t         att;
sample_t      pre_left;
sample_t      pre_right;
wide_t        mixed_left;
wide_t        mixed_right;
stereo_wide_t mixed;

//////////////  Host port  ///////////////

host_cmd_rx u_host_cmd_rx (
	.clk          (clk),
	.resetd       (resetd),
	.i_host       (i_host),
	.i_led_status (i_led_status),
	.o_host_ack   (o_host_ack),
	.o_att        (att),
	.o_led        (o_led)
);

//////////////  Audio path  //////////////

// Each channel feeds its pre value to the other
audio_mix_channel u_mix_left (
	.clk         (clk),
	.resetd      (resetd),
	.i_core      (i_core_audio.left),
	.i_linux     (i_linux_audio.left),
	.i_ctl       (i_audio_ctl),
	.i_pre_other (pre_right),
	.o_pre       (pre_left),
	.o_mixed     (mixed_left)
);

audio_mix_channel u_mix_right (
	.clk         (clk),
	.resetd      (resetd),
	.i_core      (i_core_audio.right),
	.i_linux     (i_linux_audio.right),
	.i_ctl       (i_audio_ctl),
	.i_pre_other (pre_left),
	.o_pre       (pre_right),
	.o_mixed     (mixed_right)
);

assign mixed = '{left: mixed_left, right: mixed_right};

audio_out_stage u_audio_out_stage (
	.clk     (clk),
	.resetd  (resetd),
	.i_mixed (mixed),
	.i_att   (att),
	.o_audio (o_audio)
);

endmodule

//--- hps_audio_checker.sv
`timescale 1ns/1ps

`include "sys_defs.svh"

module hps_audio_checker
	import host_pkg::*;
	import audio_pkg::*;
(
	input  logic       clk,
	input  logic       resetd,
	input  host_bus_t  i_host,
	input  stereo_t    i_core_audio,
	input  stereo_t    i_linux_audio,
	input  audio_ctl_t i_audio_ctl,
	input  led_t       i_led_status,
	input  logic       i_check,
	input  logic       i_host_ack,
	input  stereo_t    i_audio,
	input  led_t       i_led,
	output int         o_errors,
	output int         o_checks
);

int         errors = 0;
int         checks = 0;
int         since_reset;
att_t       m_att;
led_t       m_mask;
led_t       m_state;
led_t       exp_led;
logic [7:0] m_cmd;
logic       m_busy;
logic       hclk_prev;
logic       ack_h1;
logic       ack_h2;

assign o_errors = errors;
assign o_checks = checks;

// Division rounding toward minus infinity
function automatic int floor_div(input int x, input int d);
	int q;
	q = x / d;
	if (x % d != 0 && x < 0)
		q = q - 1;
	return q;
endfunction

// Core sample as a number, unsigned ones halved
function automatic int core_value(input sample_t s, input logic is_signed);
	if (is_signed)
		return int'(s);
	return int'($unsigned(s)) / 2;
endfunction

function automatic int mix_value(input int sum, input int other_pre, input mix_t mode);
	case (mode)
		2'd0: return sum;
		2'd1: return sum - floor_div(sum, 8) + floor_div(other_pre, 4);
		2'd2: return sum - floor_div(sum, 4) + floor_div(other_pre, 2);
		default: return floor_div(sum, 2) + other_pre;
	endcase
endfunction

// Mute, then shift down and saturate
function automatic int out_value(input int v, input att_t att);
	int r;
	if (att[`ATT_W-1])
		return 0;
	r = floor_div(v, 1 << att[`ATT_W-2:0]);
	if (r > 32767)
		return 32767;
	if (r < -32768)
		return -32768;
	return r;
endfunction

// Per LED, the host state wins where the override mask is set
function automatic led_t led_expected(input led_t mask, input led_t state, input led_t status);
	led_t r;
	for (int b = 0; b < `LED_W; b++)
		r[b] = mask[b] ? state[b] : status[b];
	return r;
endfunction

task automatic check_value(input string name, input int expected, input int actual);
	checks++;
	if (expected != actual) begin
		errors++;
		$display("MISMATCH t=%0t %s expected %0d got %0d", $time, name, expected, actual);
	end
endtask

task automatic check_audio();
	int sum_l;
	int sum_r;
	sum_l = core_value(i_core_audio.left, i_audio_ctl.is_signed) + int'(i_linux_audio.left);
	sum_r = core_value(i_core_audio.right, i_audio_ctl.is_signed) + int'(i_linux_audio.right);
	check_value("o_audio.left",
		out_value(mix_value(sum_l, floor_div(sum_r, 2), i_audio_ctl.mix), m_att),
		int'(i_audio.left));
	check_value("o_audio.right",
		out_value(mix_value(sum_r, floor_div(sum_l, 2), i_audio_ctl.mix), m_att),
		int'(i_audio.right));
endtask

// All sampling on the falling edge, inputs change on the rising one
always @(negedge clk) begin
	if (resetd) begin
		m_att       = '0;
		m_mask      = '0;
		m_state     = '0;
		m_cmd       = '0;
		m_busy      = 1'b0;
		hclk_prev   = 1'b0;
		ack_h1      = 1'b0;
		ack_h2      = 1'b0;
		since_reset = 0;
		check_value("o_audio.left", 0, int'(i_audio.left));
		check_value("o_audio.right", 0, int'(i_audio.right));
		check_value("o_host_ack", 0, int'(i_host_ack));
	end else begin
		check_value("o_host_ack", int'(ack_h2), int'(i_host_ack));
		ack_h2 = ack_h1;
		ack_h1 = i_host.hclk;
		if (since_reset < 3) begin
			check_value("o_audio.left", 0, int'(i_audio.left));
			check_value("o_audio.right", 0, int'(i_audio.right));
			since_reset++;
		end
		exp_led = led_expected(m_mask, m_state, i_led_status);
		check_value("o_led", int'(exp_led), int'(i_led));
		if (i_check)
			check_audio();
		// Host word decode, takes effect from the next edge on
		if (!i_host.sel) begin
			m_busy = 1'b0;
		end else if (i_host.hclk && !hclk_prev) begin
			if (!m_busy) begin
				m_cmd  = i_host.din[7:0];
				m_busy = 1'b1;
			end else if (m_cmd == `CMD_LED) begin
				m_mask  = i_host.din[15:8];
				m_state = i_host.din[7:0];
			end else if (m_cmd == `CMD_VOL) begin
				m_att = i_host.din[`ATT_W-1:0];
			end
		end
		hclk_prev = i_host.hclk;
	end
end

endmodule

//--- tb_hps_audio.sv
`timescale 1ns/1ps

`include "sys_defs.svh"

module tb_hps_audio
	import host_pkg::*;
	import audio_pkg::*;
();

localparam int N_WIN   = 300;
localparam int WIN_LEN = 16;
localparam int CMD_CYC = 40;
// Volume every 4th window, LED every 6th, plus the directed ones
localparam int N_CMDS  = N_WIN / 4 + N_WIN / 6 + 4;
localparam int MARGIN  = 2040;
localparam int LIMIT   = N_WIN * WIN_LEN + N_CMDS * CMD_CYC + MARGIN;
// A spike that leaked through the filter would reach o_audio at the strobe
localparam int SPIKE_AT = 5;

logic       clk;
logic       resetd;
host_bus_t  host;
stereo_t    core_audio;
stereo_t    linux_audio;
audio_ctl_t audio_ctl;
led_t       led_status;
logic       check_strobe;
logic       host_ack;
stereo_t    audio;
led_t       led;
int         errors;
int         checks;
int         cycles = 0;
integer     seed;

hps_audio_core u_hps_audio_core (
	.clk           (clk),
	.resetd        (resetd),
	.i_host        (host),
	.i_core_audio  (core_audio),
	.i_linux_audio (linux_audio),
	.i_audio_ctl   (audio_ctl),
	.i_led_status  (led_status),
	.o_host_ack    (host_ack),
	.o_audio       (audio),
	.o_led         (led)
);

hps_audio_checker u_checker (
	.clk           (clk),
	.resetd        (resetd),
	.i_host        (host),
	.i_core_audio  (core_audio),
	.i_linux_audio (linux_audio),
	.i_audio_ctl   (audio_ctl),
	.i_led_status  (led_status),
	.i_check       (check_strobe),
	.i_host_ack    (host_ack),
	.i_audio       (audio),
	.i_led         (led),
	.o_errors      (errors),
	.o_checks      (checks)
);

initial begin
	clk = 1'b0;
	forever #4 clk = ~clk;
end

always @(posedge clk) begin
	cycles++;
	if (cycles >= LIMIT) begin
		$display("Timeout: the test did not finish within %0d cycles", LIMIT);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		$display(">>> FAIL");
		$finish;
	end
end

// Mostly random, sometimes full scale
function automatic sample_t rand_sample();
	int r;
	r = $random(seed);
	if (r[2:0] == 3'd0)
		return 16'h7fff;
	if (r[2:0] == 3'd1)
		return 16'h8000;
	return r[31:16];
endfunction

task automatic wait_ack(input logic level);
	@(negedge clk);
	while (host_ack !== level)
		@(negedge clk);
endtask

task automatic send_word(input host_word_t w);
	@(posedge clk);
	host.din  <= w;
	host.hclk <= 1'b1;
	wait_ack(1'b1);
	@(posedge clk);
	host.hclk <= 1'b0;
	wait_ack(1'b0);
endtask

task automatic host_command(input logic [7:0] code, input host_word_t data, input int n_data);
	@(posedge clk);
	host.sel <= 1'b1;
	send_word({8'h00, code});
	for (int i = 0; i < n_data; i++)
		send_word(data + host_word_t'(i));
	@(posedge clk);
	host.sel <= 1'b0;
endtask

task automatic volume_command();
	int   r;
	att_t att;
	r = $random(seed);
	att = {r[2:0] == 3'd0, r[5] ? r[9:6] : {2'b00, r[4:3]}};
	host_command(`CMD_VOL, {r[31:21], att}, 1);
endtask

// One hold window, strobe on its last cycle
task automatic run_window(input int spike_len);
	stereo_t core;
	int      r;
	core.left  = rand_sample();
	core.right = rand_sample();
	r = $random(seed);
	for (int i = 0; i < WIN_LEN - 1; i++) begin
		@(posedge clk);
		if (i == 0) begin
			linux_audio.left  <= rand_sample();
			linux_audio.right <= rand_sample();
			audio_ctl.mix       <= r[1:0];
			audio_ctl.is_signed <= r[2];
			led_status          <= r[15:8];
		end
		if (i >= SPIKE_AT && i < SPIKE_AT + spike_len)
			core_audio <= '{left: ~core.left, right: ~core.right};
		else
			core_audio <= core;
		check_strobe <= (i == WIN_LEN - 2);
	end
	@(posedge clk);
	check_strobe <= 1'b0;
endtask

initial begin
	int r;
	seed         = 9;
	resetd       = 1'b1;
	host         = '0;
	core_audio   = '0;
	// Live stream while in reset, the outputs still read zero
	linux_audio  = '{left: 16'h4000, right: 16'hc000};
	audio_ctl    = '0;
	led_status   = '0;
	check_strobe = 1'b0;
	repeat (5) @(posedge clk);
	resetd <= 1'b0;
	repeat (4) @(posedge clk);

	////////////  Directed host  /////////////
	host_command(`CMD_LED, 16'hf0a5, 1);
	// Words while deselected must be ignored
	send_word({8'h00, `CMD_LED});
	send_word(16'h00ff);
	host_command(8'h30, 16'hff1f, 2);
	host_command(`CMD_VOL, 16'h0000, 1);

	////////////  Random windows  ////////////
	for (int k = 0; k < N_WIN; k++) begin
		if (k % 4 == 0)
			volume_command();
		if (k % 6 == 3)
			host_command(`CMD_LED, host_word_t'($random(seed)), 1 + (k % 12) / 6);
		r = $random(seed);
		run_window((r[1:0] == 2'd0) ? 1 + int'(r[2]) : 0);
	end
	repeat (4) @(posedge clk);

	$display("Checks run: %0d, errors: %0d", checks, errors);
	if (errors == 0)
		$display(">>> PASS");
	else
		$display(">>> FAIL");
	$finish;
end

endmodule

//--- src.f
+incdir+.
host_pkg.sv
audio_pkg.sv
host_cmd_rx.sv
audio_mix_channel.sv
audio_out_stage.sv
hps_audio_core.sv
hps_audio_checker.sv
tb_hps_audio.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_hps_audio

verilator --binary --timing --assert -j 0 \
	--top-module "$TOP" -f src.f -Mdir obj_dir -o sim_bin
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_bin > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
	echo "No result line found in $LOG"
	exit 1
fi
exit 0
